// File: design/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] FETCH_RESET_PC = 32'h1eceb000;

    // backing memory and cache geometry
    localparam int BMEM_DATA_W    = 64;
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = 4;
    localparam int BEAT_IDX_W     = $clog2(BEATS_PER_LINE);
    localparam int ICACHE_SETS    = 8;
    localparam int IDX_W          = $clog2(ICACHE_SETS);
    localparam int OFS_W          = $clog2(LINE_W / 8);   // byte offset in a line
    localparam int WORD_IDX_W     = OFS_W - 2;
    localparam int TAG_W          = XLEN - IDX_W - OFS_W;

    localparam int FETCHQ_DEPTH = 8;
    localparam int FQ_PTR_W     = $clog2(FETCHQ_DEPTH);

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            valid;
    } fetch_req_t;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic            valid;
    } fetch_rsp_t;

    typedef struct packed {
        logic [LINE_W-1:0] line;
        logic              valid;
    } line_fill_t;

endpackage

// File: design/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          redirect_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]    redirect_pc_i,
    input  logic                          queue_full_i,

    input  fetch_pkg::fetch_rsp_t         rsp_i,
    output fetch_pkg::fetch_req_t         req_o,

    output logic                          push_o,
    output fetch_pkg::fetch_entry_t       push_entry_o,
    output logic                          flush_o
);

    logic [fetch_pkg::XLEN-1:0] pc;
    logic                       outstanding;   // one request in the icache
    logic                       stale;         // its answer belongs to the old path
    logic                       issue;
    logic                       rsp_take;

    // no new request while one is in flight, the queue is full or a redirect lands
    assign issue    = !outstanding && !queue_full_i && !redirect_valid_i;
    assign rsp_take = rsp_i.valid && outstanding;

    assign req_o.valid = issue;
    assign req_o.addr  = pc;

    assign push_o            = rsp_take && !stale && !redirect_valid_i;
    assign push_entry_o.pc   = pc;
    assign push_entry_o.inst = rsp_i.inst;

    assign flush_o = redirect_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= fetch_pkg::FETCH_RESET_PC;
            outstanding <= 1'b0;
            stale       <= 1'b0;
        end else begin
            if (redirect_valid_i) begin
                pc <= redirect_pc_i;
            end else if (push_o) begin
                pc <= pc + fetch_pkg::XLEN'(4);
            end

            if (issue) begin
                outstanding <= 1'b1;
            end else if (rsp_take) begin
                outstanding <= 1'b0;
            end

            // a response in the redirect cycle is simply dropped
            if (redirect_valid_i) begin
                stale <= outstanding && !rsp_take;
            end else if (rsp_take) begin
                stale <= 1'b0;
            end
        end
    end

endmodule

// File: design/icache.sv
`timescale 1ns/10ps

module icache (
    input  logic                          clk,
    input  logic                          rst,

    input  fetch_pkg::fetch_req_t         req_i,
    output fetch_pkg::fetch_rsp_t         rsp_o,

    output logic [fetch_pkg::XLEN-1:0]    bmem_addr_o,
    output logic                          bmem_read_o,
    input  logic                          bmem_ready_i,

    input  fetch_pkg::line_fill_t         fill_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REQUEST,
        ST_WAIT_FILL
    } state_t;

    state_t state;
    state_t state_next;

    logic [fetch_pkg::TAG_W-1:0]       tag_arr [fetch_pkg::ICACHE_SETS];
    logic [fetch_pkg::LINE_W-1:0]      data_arr [fetch_pkg::ICACHE_SETS];
    logic [fetch_pkg::ICACHE_SETS-1:0] valid_arr;

    logic [fetch_pkg::XLEN-1:0]        req_addr;
    logic [fetch_pkg::TAG_W-1:0]       req_tag;
    logic [fetch_pkg::IDX_W-1:0]       req_idx;
    logic [fetch_pkg::WORD_IDX_W-1:0]  req_word;
    logic                              hit;
    logic                              accept;
    logic                              fill_done;

    assign req_tag  = req_addr[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_W];
    assign req_idx  = req_addr[fetch_pkg::OFS_W +: fetch_pkg::IDX_W];
    assign req_word = req_addr[2 +: fetch_pkg::WORD_IDX_W];

    assign hit       = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);
    assign accept    = (state == ST_IDLE) && req_i.valid;
    assign fill_done = (state == ST_WAIT_FILL) && fill_i.valid;

    assign rsp_o.valid = (state == ST_LOOKUP) && hit;
    assign rsp_o.inst  = data_arr[req_idx][req_word * fetch_pkg::XLEN +: fetch_pkg::XLEN];

    // line aligned refill address
    assign bmem_addr_o = {req_tag, req_idx, {fetch_pkg::OFS_W{1'b0}}};
    assign bmem_read_o = (state == ST_REQUEST) && bmem_ready_i;

    always_comb begin
        state_next = state;
        unique case (state)
            ST_IDLE: begin
                if (req_i.valid) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_next = hit ? ST_IDLE : ST_REQUEST;
            end
            ST_REQUEST: begin
                if (bmem_ready_i) begin
                    state_next = ST_WAIT_FILL;
                end
            end
            ST_WAIT_FILL: begin
                // installed line is looked up again and answered next cycle
                if (fill_i.valid) begin
                    state_next = ST_LOOKUP;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            valid_arr <= '0;
        end else begin
            state <= state_next;
            if (fill_done) begin
                valid_arr[req_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= req_i.addr;
        end
        if (fill_done) begin
            tag_arr[req_idx]  <= req_tag;
            data_arr[req_idx] <= fill_i.line;
        end
    end

endmodule

// File: design/cacheline_adapter.sv
`timescale 1ns/10ps

module cacheline_adapter (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [fetch_pkg::BMEM_DATA_W-1:0]   bmem_rdata_i,
    input  logic                                bmem_rvalid_i,

    output fetch_pkg::line_fill_t               fill_o
);

    logic [fetch_pkg::BEAT_IDX_W-1:0] beat_cnt;
    logic [fetch_pkg::LINE_W-1:0]     line_buf;
    logic                             fill_valid;
    logic                             last_beat;

    assign last_beat = bmem_rvalid_i &&
                       (beat_cnt == fetch_pkg::BEAT_IDX_W'(fetch_pkg::BEATS_PER_LINE - 1));

    assign fill_o.line  = line_buf;
    assign fill_o.valid = fill_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= '0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= last_beat;       // one cycle after the fourth beat
            if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;   // wraps back to 0 after the last beat
            end
        end
    end

    // lowest beat lands in the low bits
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_buf[beat_cnt * fetch_pkg::BMEM_DATA_W +: fetch_pkg::BMEM_DATA_W] <= bmem_rdata_i;
        end
    end

endmodule

// File: design/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,

    input  logic                       push_i,
    input  fetch_pkg::fetch_entry_t    push_data_i,

    input  logic                       pop_i,
    output fetch_pkg::fetch_entry_t    pop_data_o,

    output logic                       full_o,
    output logic                       empty_o
);

    // extra msb tells full from empty
    logic [fetch_pkg::FQ_PTR_W:0] wr_ptr;
    logic [fetch_pkg::FQ_PTR_W:0] rd_ptr;

    fetch_pkg::fetch_entry_t      mem [fetch_pkg::FETCHQ_DEPTH];

    logic                         do_push;
    logic                         do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[fetch_pkg::FQ_PTR_W] != rd_ptr[fetch_pkg::FQ_PTR_W]) &&
                     (wr_ptr[fetch_pkg::FQ_PTR_W-1:0] == rd_ptr[fetch_pkg::FQ_PTR_W-1:0]);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign pop_data_o = mem[rd_ptr[fetch_pkg::FQ_PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[fetch_pkg::FQ_PTR_W-1:0]] <= push_data_i;
        end
    end

endmodule

// File: design/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
    input  logic                                clk,
    input  logic                                rst,

    output logic [fetch_pkg::XLEN-1:0]          bmem_addr_o,
    output logic                                bmem_read_o,
    input  logic                                bmem_ready_i,

    input  logic [fetch_pkg::XLEN-1:0]          bmem_raddr_i,   // beats come in order, not needed
    input  logic [fetch_pkg::BMEM_DATA_W-1:0]   bmem_rdata_i,
    input  logic                                bmem_rvalid_i,

    input  logic                                redirect_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]          redirect_pc_i,

    output logic                                fetch_valid_o,
    output fetch_pkg::fetch_entry_t             fetch_entry_o,
    input  logic                                fetch_ready_i
);

    fetch_pkg::fetch_req_t   req;
    fetch_pkg::fetch_rsp_t   rsp;
    fetch_pkg::line_fill_t   fill;
    fetch_pkg::fetch_entry_t push_entry;

    logic push;
    logic flush;
    logic q_full;
    logic q_empty;
    logic pop;

    assign fetch_valid_o = !q_empty;
    assign pop           = fetch_valid_o && fetch_ready_i;

    fetch_ctrl u_fetch_ctrl (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .queue_full_i     (q_full),
        .rsp_i            (rsp),
        .req_o            (req),
        .push_o           (push),
        .push_entry_o     (push_entry),
        .flush_o          (flush)
    );

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .rsp_o        (rsp),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_ready_i (bmem_ready_i),
        .fill_i       (fill)
    );

    cacheline_adapter u_cacheline_adapter (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .fill_o        (fill)
    );

    fetch_queue u_fetch_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush),
        .push_i      (push),
        .push_data_i (push_entry),
        .pop_i       (pop),
        .pop_data_o  (fetch_entry_o),
        .full_o      (q_full),
        .empty_o     (q_empty)
    );

endmodule

// File: verif/bmem_model.sv
`timescale 1ns/10ps

module bmem_model #(
    parameter logic [15:0] SEED    = 16'h0001,
    parameter logic [31:0] PATTERN = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        read_i,
    input  logic [31:0] addr_i,
    output logic        ready_o,
    output logic [31:0] raddr_o,
    output logic [63:0] rdata_o,
    output logic        rvalid_o,
    output logic        busy_o
);

    logic [15:0] lfsr;

    // galois lfsr, one step per bit
    function automatic logic rand_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return lsb;
    endfunction

    // lower word address sits in the low half of a beat
    function automatic logic [63:0] beat_data(input logic [31:0] addr);
        return {(addr + 32'd4) ^ PATTERN, addr ^ PATTERN};
    endfunction

    initial begin
        logic [31:0] line_addr;
        int          delay;
        lfsr     = SEED;
        ready_o  = 1'b1;
        raddr_o  = '0;
        rdata_o  = '0;
        rvalid_o = 1'b0;
        busy_o   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && read_i) begin
                line_addr = addr_i;
                busy_o    = 1'b1;
                delay     = 2;   // 2 to 9 cycles
                for (int b = 0; b < 3; b++) begin
                    delay = delay + (rand_bit() ? (1 << b) : 0);
                end
                repeat (delay) @(posedge clk);
                for (int beat = 0; beat < 4; beat++) begin
                    #2;
                    rvalid_o = 1'b1;
                    raddr_o  = line_addr + 32'(8 * beat);
                    rdata_o  = beat_data(raddr_o);
                    @(posedge clk);
                end
                #2;
                rvalid_o = 1'b0;
                busy_o   = 1'b0;
            end
        end
    end

endmodule

// File: verif/tb_fetch.sv
`timescale 1ns/10ps

module tb_fetch;

    localparam int          CLK_PERIOD      = 40;
    localparam int          WATCHDOG_CYCLES = 20000;
    localparam logic [15:0] LFSR_SEED       = 16'd61427;
    localparam logic [31:0] MEM_PATTERN     = 32'ha5a50000;
    localparam logic [31:0] BASE_PC         = fetch_pkg::FETCH_RESET_PC;
    localparam logic [31:0] MISS_PC         = 32'h1eceb8c4;   // set 6, never cached before

    logic                    clk;
    logic                    rst;
    logic [31:0]             bmem_addr;
    logic                    bmem_read;
    logic                    bmem_ready;
    logic [31:0]             bmem_raddr;
    logic [63:0]             bmem_rdata;
    logic                    bmem_rvalid;
    logic                    mem_busy;
    logic                    redirect_valid;
    logic [31:0]             redirect_pc;
    logic                    fetch_valid;
    fetch_pkg::fetch_entry_t fetch_entry;
    logic                    fetch_ready;

    logic [15:0] lfsr;
    logic [31:0] read_addrs[$];
    int          errors;
    int          checks;

    fetch_top u_fetch_top (
        .clk              (clk),
        .rst              (rst),
        .bmem_addr_o      (bmem_addr),
        .bmem_read_o      (bmem_read),
        .bmem_ready_i     (bmem_ready),
        .bmem_raddr_i     (bmem_raddr),
        .bmem_rdata_i     (bmem_rdata),
        .bmem_rvalid_i    (bmem_rvalid),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .fetch_valid_o    (fetch_valid),
        .fetch_entry_o    (fetch_entry),
        .fetch_ready_i    (fetch_ready)
    );

    bmem_model #(.SEED(LFSR_SEED), .PATTERN(MEM_PATTERN)) u_bmem_model (
        .clk      (clk),
        .rst      (rst),
        .read_i   (bmem_read),
        .addr_i   (bmem_addr),
        .ready_o  (bmem_ready),
        .raddr_o  (bmem_raddr),
        .rdata_o  (bmem_rdata),
        .rvalid_o (bmem_rvalid),
        .busy_o   (mem_busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (!rst && bmem_read) begin
            read_addrs.push_back(bmem_addr);
        end
    end

    function automatic logic rand_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ MEM_PATTERN;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_true(!fetch_valid && !bmem_read, "fetch or bmem read active during reset");
        @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    // pops count entries and checks the +4 pc chain and the memory word
    task automatic take_entries(input int count, input logic [31:0] first_pc,
                                input logic random_ready);
        logic [31:0] exp_pc;
        int          taken;
        exp_pc = first_pc;
        taken  = 0;
        while (taken < count) begin
            @(posedge clk);
            #2;
            fetch_ready = random_ready ? rand_bit() : 1'b1;
            @(negedge clk);
            if (fetch_valid && fetch_ready) begin
                check_word("fetch_entry_o.pc", fetch_entry.pc, exp_pc);
                check_word("fetch_entry_o.inst", fetch_entry.inst, mem_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                taken++;
            end
        end
        @(posedge clk);
        #2;
        fetch_ready = 1'b0;
    endtask

    task automatic wait_read_count(input int count);
        while (read_addrs.size() < count) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_mem_idle();
        @(negedge clk);
        while (mem_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(posedge clk);
        #2;
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(posedge clk);
        #2;
        redirect_valid = 1'b0;
        @(negedge clk);
        check_true(!fetch_valid, "fetch queue not empty after redirect");
    endtask

    task automatic seq_fetch();
        take_entries(32, BASE_PC, 1'b0);
        check_word("bmem read count", 32'(read_addrs.size()), 32'd4);
        for (int i = 0; i < 4 && i < read_addrs.size(); i++) begin
            check_word("bmem_addr_o", read_addrs[i], BASE_PC + 32'(32 * i));
        end
    endtask

    task automatic queue_full_stall();
        int reads_seen;
        wait_read_count(5);
        check_word("bmem_addr_o", read_addrs[4], BASE_PC + 32'h80);
        wait_mem_idle();
        reads_seen = read_addrs.size();
        repeat (40) @(negedge clk);
        check_true(read_addrs.size() == reads_seen, "bmem read issued while the queue was full");
        for (int i = 0; i < fetch_pkg::FETCHQ_DEPTH; i++) begin
            @(posedge clk);
            #2;
            fetch_ready = 1'b1;
            @(negedge clk);
            check_true(fetch_valid, "queue ran dry before its depth was drained");
            check_word("fetch_entry_o.pc", fetch_entry.pc, BASE_PC + 32'h80 + 32'(4 * i));
            check_word("fetch_entry_o.inst", fetch_entry.inst,
                       mem_word(BASE_PC + 32'h80 + 32'(4 * i)));
        end
        @(posedge clk);
        #2;
        fetch_ready = 1'b0;
        @(negedge clk);
        check_true(!fetch_valid, "more entries buffered than the queue depth");
    endtask

    task automatic redirect_on_miss();
        wait_read_count(6);   // refill of line a0 now in flight
        check_word("bmem_addr_o", read_addrs[5], BASE_PC + 32'ha0);
        redirect_to(MISS_PC);
        take_entries(4, MISS_PC, 1'b0);
        check_true(read_addrs.size() >= 7, "no refill seen for the redirect target");
        if (read_addrs.size() >= 7) begin
            check_word("bmem_addr_o", read_addrs[6], MISS_PC & ~32'h1f);
        end
    endtask

    task automatic hit_reuse();
        int reads_seen;
        wait_read_count(8);
        wait_mem_idle();
        redirect_to(BASE_PC);
        reads_seen = read_addrs.size();
        take_entries(32, BASE_PC, 1'b0);
        check_word("bmem read count", 32'(read_addrs.size()), 32'(reads_seen));
    endtask

    task automatic ready_backpressure();
        int reads_seen;
        reads_seen = read_addrs.size();
        take_entries(48, BASE_PC + 32'h80, 1'b1);
        // line a0 was installed by the dropped refill, so c0 misses first
        check_true(read_addrs.size() > reads_seen, "no refill seen under back-pressure");
        if (read_addrs.size() > reads_seen) begin
            check_word("bmem_addr_o", read_addrs[reads_seen], BASE_PC + 32'hc0);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        fetch_ready    = 1'b0;
        lfsr           = LFSR_SEED;
        errors         = 0;
        checks         = 0;
        apply_reset();
        seq_fetch();
        queue_full_stall();
        redirect_on_miss();
        hit_reuse();
        ready_backpressure();
        repeat (2) @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// File: verilog.f
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/icache.sv
design/cacheline_adapter.sv
design/fetch_queue.sv
design/fetch_top.sv
verif/bmem_model.sv
verif/tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_fetch -o tb_fetch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$log"; then
    exit 1
fi
exit 0
